/* rtl/ahb_pkg.sv */
package ahb_pkg;

    // bus widths
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;

    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hsize_t;
    typedef logic [2:0]  hburst_t;
    typedef logic [1:0]  hresp_t;

    // transfer type
    localparam htrans_t IDLE   = 2'b00;
    localparam htrans_t BUSY   = 2'b01;
    localparam htrans_t SEQ    = 2'b10;
    localparam htrans_t NONSEQ = 2'b11;

    // transfer size, only full words on this bus
    localparam hsize_t  SIZE_WORD = 3'b010;

    // single transfers only, no bursts
    localparam hburst_t BURST_SINGLE = 3'b000;

    // slave response
    localparam hresp_t  RESP_OKAY = 2'b00;

endpackage

/* rtl/led_pkg.sv */
package led_pkg;

    // gpio block in the memory map
    localparam ahb_pkg::haddr_t GPIO_BASE = 32'h4000_0000;

    localparam logic [3:0] OFS_DATA_RO = 4'h0;  // key inputs
    localparam logic [3:0] OFS_DATA    = 4'h4;  // led outputs
    localparam logic [3:0] OFS_DIRM    = 4'h8;
    localparam logic [3:0] OFS_OEN     = 4'hC;

    // pins are active low
    typedef logic [3:0] led_bits_t;
    typedef logic [3:0] key_bits_t;
    typedef logic [3:0] led_mode_t;  // one-hot, zero until a key is seen

    localparam led_bits_t LED_ALL_OFF = 4'b1111;

    localparam led_mode_t MODE_RUN    = 4'b0001;
    localparam led_mode_t MODE_FAST   = 4'b0010;
    localparam led_mode_t MODE_BEAT   = 4'b0100;
    localparam led_mode_t MODE_BREATH = 4'b1000;

    // led field sits at bits 7..4 of DATA, DIRM and OEN
    localparam int GPIO_FIELD_LSB = 4;
    localparam ahb_pkg::hdata_t CONFIG_WORD = 32'h0000_00F0;

    // frame timing, short enough for simulation
    localparam int FRAME_CYCLES     = 400;
    localparam int TIMER_W          = $clog2(FRAME_CYCLES);
    localparam int EIGHTH_CYCLES    = FRAME_CYCLES / 8;
    localparam int TENTH_CYCLES     = FRAME_CYCLES / 10;
    localparam int TWENTIETH_CYCLES = FRAME_CYCLES / 20;

    typedef logic [TIMER_W-1:0] timer_t;

endpackage

/* rtl/led_pattern_gen.sv */
`timescale 1ns/10ps

module led_pattern_gen (
    input  logic               iHCLK,
    input  logic               iHRESETn,
    input  led_pkg::led_mode_t mode,
    output led_pkg::led_bits_t pattern
);

    led_pkg::timer_t timer;
    led_pkg::timer_t duty_mask;
    logic [4:0]      eighth;     // 0..7
    logic [4:0]      tenth;      // 0..9
    logic [4:0]      twentieth;  // 0..19
    logic [2:0]      breath_k;

    // which slot of length len the timer is in
    function automatic logic [4:0] slot_of(input led_pkg::timer_t t, input int len);
        logic [4:0] slot;
        slot = '0;
        for (int i = 1; i < 20; i++) begin
            if (int'(t) >= i * len) begin
                slot = 5'(i);
            end
        end
        return slot;
    endfunction

    // frame timer
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            timer <= '0;
        end else if (timer == led_pkg::timer_t'(led_pkg::FRAME_CYCLES - 1)) begin
            timer <= '0;  // wrap at end of frame
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign eighth    = slot_of(timer, led_pkg::EIGHTH_CYCLES);
    assign tenth     = slot_of(timer, led_pkg::TENTH_CYCLES);
    assign twentieth = slot_of(timer, led_pkg::TWENTIETH_CYCLES);

    // duty exponent, brightest in the middle of the frame
    always_comb begin
        case (tenth)
            5'd1, 5'd8: breath_k = 3'd5;  // 1 in 32
            5'd2, 5'd7: breath_k = 3'd4;
            5'd3, 5'd6: breath_k = 3'd3;
            default:    breath_k = 3'd2;  // 1 in 4
        endcase
    end

    assign duty_mask = (led_pkg::timer_t'(1) << breath_k) - 1'b1;

    always_comb begin
        pattern = led_pkg::LED_ALL_OFF;
        case (mode)
            // one led per quarter frame, led1 first
            led_pkg::MODE_RUN: begin
                pattern = ~(led_pkg::led_bits_t'(1) << eighth[2:1]);
            end
            led_pkg::MODE_FAST: begin
                pattern = ~(led_pkg::led_bits_t'(1) << eighth[1:0]);
            end
            // two flashes just before the wrap
            led_pkg::MODE_BEAT: begin
                if (twentieth == 5'd17 || twentieth == 5'd19) begin
                    pattern = '0;
                end
            end
            led_pkg::MODE_BREATH: begin
                if (tenth != 5'd0 && tenth != 5'd9 && (timer & duty_mask) == '0) begin
                    pattern = '0;
                end
            end
            default: pattern = led_pkg::LED_ALL_OFF;  // no mode yet
        endcase
    end

    // mode register in the master never holds two modes
    mode_onehot_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        $onehot0(mode))
        else $error("mode is not one-hot: %b", mode);

endmodule

/* rtl/ahb_led_master.sv */
`timescale 1ns/10ps

module ahb_led_master (
    input  logic               iHCLK,
    input  logic               iHRESETn,
    input  logic               hready,
    input  ahb_pkg::hresp_t    hresp,
    input  ahb_pkg::hdata_t    hrdata,
    output ahb_pkg::htrans_t   htrans,
    output ahb_pkg::hsize_t    hsize,
    output ahb_pkg::hburst_t   hburst,
    output logic               hwrite,
    output ahb_pkg::haddr_t    haddr,
    output ahb_pkg::hdata_t    hwdata,
    input  led_pkg::led_bits_t pattern,
    output led_pkg::led_mode_t mode
);

    // one state per transfer
    typedef enum logic [2:0] {
        CFG_DIRM,
        CFG_OEN,
        CFG_DATA,
        POLL_KEYS,
        WRITE_LEDS
    } state_t;

    state_t             state;
    state_t             state_nxt;
    logic               xfer_done;
    logic [3:0]         ofs;
    led_pkg::key_bits_t keys_rd;
    led_pkg::led_mode_t key_mode;
    led_pkg::led_mode_t mode_nxt;
    led_pkg::led_bits_t led_q;     // pattern held while the write is stalled
    logic               led_held;  // data write already waited once
    led_pkg::led_bits_t led_wr;

    assign xfer_done = hready && (hresp == ahb_pkg::RESP_OKAY);
    assign keys_rd   = hrdata[3:0];

    // exactly one key low selects a mode
    always_comb begin
        case (keys_rd)
            4'b1110: key_mode = led_pkg::MODE_RUN;
            4'b1101: key_mode = led_pkg::MODE_FAST;
            4'b1011: key_mode = led_pkg::MODE_BEAT;
            4'b0111: key_mode = led_pkg::MODE_BREATH;
            default: key_mode = '0;
        endcase
    end

    assign mode_nxt = (state == POLL_KEYS && xfer_done && key_mode != '0) ? key_mode : mode;

    always_comb begin
        state_nxt = state;
        if (xfer_done) begin
            case (state)
                CFG_DIRM:   state_nxt = CFG_OEN;
                CFG_OEN:    state_nxt = CFG_DATA;
                CFG_DATA:   state_nxt = POLL_KEYS;
                POLL_KEYS:  state_nxt = (mode_nxt != '0) ? WRITE_LEDS : POLL_KEYS;
                WRITE_LEDS: state_nxt = POLL_KEYS;
                default:    state_nxt = CFG_DIRM;
            endcase
        end
    end

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            state <= CFG_DIRM;
            mode  <= '0;
        end else begin
            state <= state_nxt;
            mode  <= mode_nxt;
        end
    end

    // sample the pattern as the data write is issued
    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            led_held <= 1'b0;
            led_q    <= led_pkg::LED_ALL_OFF;
        end else begin
            led_held <= (state == WRITE_LEDS) && !xfer_done;
            if (state == WRITE_LEDS && !led_held) begin
                led_q <= pattern;
            end
        end
    end

    assign led_wr = led_held ? led_q : pattern;

    always_comb begin
        case (state)
            CFG_DIRM:   ofs = led_pkg::OFS_DIRM;
            CFG_OEN:    ofs = led_pkg::OFS_OEN;
            CFG_DATA,
            WRITE_LEDS: ofs = led_pkg::OFS_DATA;
            default:    ofs = led_pkg::OFS_DATA_RO;
        endcase
    end

    always_comb begin
        case (state)
            WRITE_LEDS: hwdata = ahb_pkg::hdata_t'(led_wr) << led_pkg::GPIO_FIELD_LSB;
            POLL_KEYS:  hwdata = '0;
            default:    hwdata = led_pkg::CONFIG_WORD;  // config, leds off
        endcase
    end

    assign htrans = ahb_pkg::NONSEQ;  // back to back singles
    assign hsize  = ahb_pkg::SIZE_WORD;
    assign hburst = ahb_pkg::BURST_SINGLE;
    assign haddr  = led_pkg::GPIO_BASE | ahb_pkg::haddr_t'(ofs);
    assign hwrite = (state != POLL_KEYS);

    // a stalled transfer is held unchanged
    hold_stable_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (htrans == ahb_pkg::NONSEQ && !hready)
            |=> ($stable(haddr) && $stable(hwrite) && $stable(hwdata)))
        else $error("transfer changed while stalled");

endmodule

/* rtl/ahb_gpio_slave.sv */
`timescale 1ns/10ps

module ahb_gpio_slave (
    input  logic               iHCLK,
    input  logic               iHRESETn,
    input  ahb_pkg::htrans_t   htrans,
    input  ahb_pkg::haddr_t    haddr,
    input  logic               hwrite,
    input  ahb_pkg::hdata_t    hwdata,
    input  ahb_pkg::hsize_t    hsize,
    output logic               hready,
    output ahb_pkg::hresp_t    hresp,
    output ahb_pkg::hdata_t    hrdata,
    input  logic               stall,
    input  led_pkg::key_bits_t keys,
    output led_pkg::led_bits_t led,
    output logic               led_oe
);

    logic               sel;
    logic               wr_en;
    logic [3:0]         ofs;
    led_pkg::led_bits_t wr_field;
    led_pkg::led_bits_t data_q;
    led_pkg::led_bits_t dirm_q;
    led_pkg::led_bits_t oen_q;
    led_pkg::led_bits_t pin_en;
    led_pkg::key_bits_t key_q;  // synchronized keys

    assign ofs = haddr[3:0];

    // active transfer inside the gpio window
    assign sel = (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ)
              && ((haddr & 32'hFFFF_FFF0) == led_pkg::GPIO_BASE);

    // writes land on the completing edge
    assign wr_en    = sel && hwrite && hready && (hsize == ahb_pkg::SIZE_WORD);
    assign wr_field = hwdata[led_pkg::GPIO_FIELD_LSB +: $bits(led_pkg::led_bits_t)];

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            data_q <= led_pkg::LED_ALL_OFF;
            dirm_q <= '0;
            oen_q  <= '0;
        end else if (wr_en) begin
            case (ofs)
                led_pkg::OFS_DATA: data_q <= wr_field;
                led_pkg::OFS_DIRM: dirm_q <= wr_field;
                led_pkg::OFS_OEN:  oen_q  <= wr_field;
                default: ;  // DATA_RO is read only
            endcase
        end
    end

    always_ff @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            key_q <= '1;  // released
        end else begin
            key_q <= keys;
        end
    end

    // read mux
    always_comb begin
        hrdata = '0;
        case (ofs)
            led_pkg::OFS_DATA_RO: hrdata[3:0] = key_q;
            led_pkg::OFS_DATA:    hrdata[led_pkg::GPIO_FIELD_LSB +: 4] = data_q;
            led_pkg::OFS_DIRM:    hrdata[led_pkg::GPIO_FIELD_LSB +: 4] = dirm_q;
            led_pkg::OFS_OEN:     hrdata[led_pkg::GPIO_FIELD_LSB +: 4] = oen_q;
            default:              hrdata = '0;
        endcase
    end

    assign hready = ~stall;  // wait states straight from stall
    assign hresp  = ahb_pkg::RESP_OKAY;

    // pin is driven only with both direction and enable set
    assign pin_en = dirm_q & oen_q;
    assign led    = data_q | ~pin_en;
    assign led_oe = &pin_en;

    // master never writes the key register
    no_ro_write_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (sel && hwrite && hready) |-> (ofs != led_pkg::OFS_DATA_RO))
        else $error("completed write to DATA_RO");

endmodule

/* rtl/led_gpio_top.sv */
`timescale 1ns/10ps

module led_gpio_top (
    input  logic               iHCLK,
    input  logic               iHRESETn,
    input  led_pkg::key_bits_t keys,
    input  logic               stall,
    output led_pkg::led_bits_t led,
    output logic               led_oe
);

    led_pkg::led_mode_t mode;
    led_pkg::led_bits_t pattern;

    // bus between master and gpio
    ahb_pkg::htrans_t   htrans;
    ahb_pkg::haddr_t    haddr;
    logic               hwrite;
    ahb_pkg::hsize_t    hsize;
    ahb_pkg::hdata_t    hwdata;
    logic               hready;
    ahb_pkg::hresp_t    hresp;
    ahb_pkg::hdata_t    hrdata;

    led_pattern_gen u_pattern (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .mode     (mode),
        .pattern  (pattern)
    );

    ahb_led_master u_master (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .hready   (hready),
        .hresp    (hresp),
        .hrdata   (hrdata),
        .htrans   (htrans),
        .hsize    (hsize),
        .hburst   (),  // gpio takes single transfers only
        .hwrite   (hwrite),
        .haddr    (haddr),
        .hwdata   (hwdata),
        .pattern  (pattern),
        .mode     (mode)
    );

    ahb_gpio_slave u_gpio (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .htrans   (htrans),
        .haddr    (haddr),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hsize    (hsize),
        .hready   (hready),
        .hresp    (hresp),
        .hrdata   (hrdata),
        .stall    (stall),
        .keys     (keys),
        .led      (led),
        .led_oe   (led_oe)
    );

endmodule

/* verification/tb_led_gpio.sv */
`timescale 1ns/10ps

module tb_led_gpio;

    localparam int CLK_PERIOD    = 8;
    localparam int FRAME         = led_pkg::FRAME_CYCLES;
    localparam int SETTLE_CYCLES = FRAME / 4;  // key to led bound
    localparam int TEST_FRAMES   = 15;
    localparam int MARGIN_FRAMES = 5;
    localparam int WATCHDOG_NS   = ((TEST_FRAMES + MARGIN_FRAMES) * FRAME + 8) * CLK_PERIOD;

    // sets of led values a mode may show
    localparam int SET_NONE    = 0;  // mode change in flight
    localparam int SET_OFF     = 1;
    localparam int SET_ONECOLD = 2;  // running lights
    localparam int SET_ONOFF   = 3;  // heartbeat, breathing

    logic               iHCLK = 1'b0;
    logic               iHRESETn;
    led_pkg::key_bits_t keys;
    logic               stall;
    led_pkg::led_bits_t led;
    logic               led_oe;

    int          allowed;
    int          err_cnt;
    int          err_mark;
    int          test_num;
    int          tests_failed;
    int          cyc_cnt;
    int          ready_cnt;
    bit          stall_on;
    logic [31:0] seed;
    bit          win_open;
    int          win_kind;
    int          win_len;
    int          win_cnt;
    logic [3:0]  seen_mask;     // one bit per lit led
    logic        seen_all_on;

    led_gpio_top dut0 (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .keys     (keys),
        .stall    (stall),
        .led      (led),
        .led_oe   (led_oe)
    );

    always #(CLK_PERIOD / 2) iHCLK = ~iHCLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit in_set(input logic [3:0] v, input int kind);
        case (kind)
            SET_OFF:     return v == 4'hF;
            SET_ONECOLD: return v == 4'hE || v == 4'hD || v == 4'hB || v == 4'h7;
            SET_ONOFF:   return v == 4'h0 || v == 4'hF;
            default:     return 1'b1;
        endcase
    endfunction

    // cycles and completed transfers since reset
    always @(posedge iHCLK or negedge iHRESETn) begin
        if (!iHRESETn) begin
            cyc_cnt   <= 0;
            ready_cnt <= 0;
        end else begin
            cyc_cnt <= cyc_cnt + 1;
            if (!stall && ready_cnt < 3) begin
                ready_cnt <= ready_cnt + 1;
            end
        end
    end

    // observation window for the values a mode must show
    always @(posedge iHCLK) begin
        if (!win_open) begin
            win_cnt     <= 0;
            seen_mask   <= 4'h0;
            seen_all_on <= 1'b0;
        end else begin
            win_cnt <= win_cnt + 1;
            case (led)
                4'hE:    seen_mask[0] <= 1'b1;
                4'hD:    seen_mask[1] <= 1'b1;
                4'hB:    seen_mask[2] <= 1'b1;
                4'h7:    seen_mask[3] <= 1'b1;
                4'h0:    seen_all_on  <= 1'b1;
                default: ;
            endcase
        end
    end

    // random back-pressure, one draw per cycle
    initial begin
        stall = 1'b0;
        seed  = 32'ha75923f3;
        forever begin
            @(posedge iHCLK);
            #1;
            if (stall_on) begin
                seed  = lcg_next(seed);
                stall = seed[31];
            end else begin
                stall = 1'b0;
            end
        end
    end

    reset_state_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (cyc_cnt == 0) |-> (!led_oe && led == 4'hF))
        else begin
            err_cnt++;
            $display("FAIL led_oe=%h led=%h right after reset", $sampled(led_oe), $sampled(led));
        end

    oe_bound_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (ready_cnt >= 3) |-> led_oe)
        else begin
            err_cnt++;
            $display("FAIL led_oe=%h after three transfers, expected 1", $sampled(led_oe));
        end

    led_set_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        in_set(led, allowed))
        else begin
            err_cnt++;
            $display("FAIL led=%h outside value set %0d", $sampled(led), $sampled(allowed));
        end

    stall_hold_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        stall |=> ($stable(led) && $stable(led_oe)))
        else begin
            err_cnt++;
            $display("FAIL led=%h led_oe=%h changed while stalled", $sampled(led),
                     $sampled(led_oe));
        end

    all_four_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (win_open && win_kind == SET_ONECOLD && win_cnt == win_len) |-> (seen_mask == 4'hF))
        else begin
            err_cnt++;
            $display("FAIL seen_mask=%h over the window, expected f", $sampled(seen_mask));
        end

    flash_a: assert property (@(posedge iHCLK) disable iff (!iHRESETn)
        (win_open && win_kind == SET_ONOFF && win_cnt == win_len) |-> seen_all_on)
        else begin
            err_cnt++;
            $display("FAIL seen_all_on=%h over one frame, expected 1", $sampled(seen_all_on));
        end

    // new key value, then wait for led to reach the new mode's values
    task automatic press_keys(input led_pkg::key_bits_t val, input int kind);
        int waited;
        waited = 0;
        keys   = val;
        if (kind != allowed) begin
            allowed = SET_NONE;
            while (!in_set(led, kind) && waited < SETTLE_CYCLES) begin
                @(posedge iHCLK);
                #1;
                waited++;
            end
            if (!in_set(led, kind)) begin
                err_cnt++;
                $display("led did not follow keys %h within %0d cycles", val, SETTLE_CYCLES);
            end
            allowed = kind;
        end
    endtask

    task automatic watch_leds(input int kind, input int len);
        win_kind = kind;
        win_len  = len;
        win_open = 1'b1;
        repeat (len + 1) @(posedge iHCLK);
        #1;
        win_open = 1'b0;
        @(posedge iHCLK);
        #1;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (err_cnt == err_mark) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        iHRESETn     = 1'b0;
        keys         = 4'hF;  // all released
        allowed      = SET_OFF;
        stall_on     = 1'b0;
        win_open     = 1'b0;
        win_kind     = SET_NONE;
        win_len      = 0;
        err_cnt      = 0;
        err_mark     = 0;
        test_num     = 0;
        tests_failed = 0;
        repeat (8) @(posedge iHCLK);
        #1;
        iHRESETn = 1'b1;

        watch_leds(SET_NONE, FRAME);
        end_test("reset and configuration");

        press_keys(4'b1110, SET_ONECOLD);
        watch_leds(SET_ONECOLD, 2 * FRAME);
        end_test("running light");

        press_keys(4'b1101, SET_ONECOLD);
        watch_leds(SET_ONECOLD, 2 * FRAME);
        press_keys(4'b1011, SET_ONOFF);
        watch_leds(SET_ONOFF, FRAME);
        watch_leds(SET_ONOFF, FRAME);
        end_test("fast light and heartbeat");

        press_keys(4'b0111, SET_ONOFF);
        watch_leds(SET_ONOFF, FRAME);
        press_keys(4'hF, SET_ONOFF);  // mode must persist
        watch_leds(SET_ONOFF, FRAME);
        end_test("breathing and release");

        stall_on = 1'b1;
        press_keys(4'b1110, SET_ONECOLD);
        watch_leds(SET_ONECOLD, 2 * FRAME);
        press_keys(4'b0111, SET_ONOFF);
        watch_leds(SET_NONE, FRAME);
        press_keys(4'hF, SET_ONOFF);
        stall_on = 1'b0;
        end_test("random stall");

        // two keys low, breathing stays
        press_keys(4'b1100, SET_ONOFF);
        watch_leds(SET_NONE, FRAME);
        press_keys(4'hF, SET_ONOFF);
        end_test("two keys pressed");

        $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

/* sim.f */
rtl/ahb_pkg.sv
rtl/led_pkg.sv
rtl/led_pattern_gen.sv
rtl/ahb_led_master.sv
rtl/ahb_gpio_slave.sv
rtl/led_gpio_top.sv
verification/tb_led_gpio.sv

/* Makefile */
# Verilator build and run of the LED sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_led_gpio
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
